// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data word and pc width
`define CORE_XLEN 32

// architectural registers including r0
`define CORE_REG_COUNT 32

`define CORE_REG_IDX_W 5

`endif

// File: design/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    localparam int unsigned reg_count = `CORE_REG_COUNT;

    typedef logic [`CORE_XLEN-1:0]      word_t;
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // primary opcode in inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f
    } opcode_e;

    // special function field in inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

endpackage

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic               aclk,
    input  logic               arst_n,
    input  core_pkg::reg_idx_t rs_num,
    input  core_pkg::reg_idx_t rt_num,
    output core_pkg::word_t    rs_data,
    output core_pkg::word_t    rt_data,
    input  logic               wen,
    input  core_pkg::reg_idx_t wnum,
    input  core_pkg::word_t    wdata
);

    // no storage behind r0
    core_pkg::word_t regs [1:core_pkg::reg_count-1];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wnum != '0) begin
            regs[wnum] <= wdata;
        end
    end

    assign rs_data = (rs_num == '0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 : regs[rt_num];

    // result stage drops r0 writes before they get here
    a_no_r0_write: assert property (
        @(posedge aclk) disable iff (!arst_n)
        wen |-> wnum != '0
    );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module decode_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  core_pkg::word_t     in_pc,
    input  core_pkg::word_t     in_inst,
    output logic                in_ready,
    output core_pkg::reg_idx_t  rs_num,
    output core_pkg::reg_idx_t  rt_num,
    input  core_pkg::word_t     rs_data,
    input  core_pkg::word_t     rt_data,
    input  logic                exe_wen,
    input  core_pkg::reg_idx_t  exe_wnum,
    input  logic                res_wen,
    input  core_pkg::reg_idx_t  res_wnum,
    output logic                dec_valid,
    output core_pkg::word_t     dec_pc,
    output core_pkg::alu_op_e   dec_alu_op,
    output core_pkg::word_t     dec_src_a,
    output core_pkg::word_t     dec_src_b,
    output logic                dec_wen,
    output core_pkg::reg_idx_t  dec_wnum,
    input  logic                exe_ready
);

    logic               ds_valid;
    core_pkg::word_t    ds_pc;
    core_pkg::word_t    ds_inst;

    core_pkg::opcode_e  opcode;
    core_pkg::funct_e   funct;
    core_pkg::reg_idx_t rd_num;
    logic [4:0]         sa;
    logic [15:0]        imm;

    logic               is_special;
    logic               is_shift;
    logic               op_known;
    logic               rs_used;
    logic               rt_used;
    logic               rs_hit;
    logic               rt_hit;
    logic               hazard;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (in_ready) begin
            ds_valid <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_ready) begin
            ds_pc   <= in_pc;
            ds_inst <= in_inst;
        end
    end

    assign opcode     = core_pkg::opcode_e'(ds_inst[31:26]);
    assign funct      = core_pkg::funct_e'(ds_inst[5:0]);
    assign rs_num     = ds_inst[25:21];
    assign rt_num     = ds_inst[20:16];
    assign rd_num     = ds_inst[15:11];
    assign sa         = ds_inst[10:6];
    assign imm        = ds_inst[15:0];
    assign is_special = (opcode == core_pkg::op_special);

    always_comb begin
        dec_alu_op = core_pkg::alu_add;
        op_known   = 1'b1;
        is_shift   = 1'b0;
        if (is_special) begin
            case (funct)
                core_pkg::fn_sll: begin
                    dec_alu_op = core_pkg::alu_sll;
                    is_shift   = 1'b1;
                end
                core_pkg::fn_srl: begin
                    dec_alu_op = core_pkg::alu_srl;
                    is_shift   = 1'b1;
                end
                core_pkg::fn_sra: begin
                    dec_alu_op = core_pkg::alu_sra;
                    is_shift   = 1'b1;
                end
                core_pkg::fn_addu: dec_alu_op = core_pkg::alu_add;
                core_pkg::fn_subu: dec_alu_op = core_pkg::alu_sub;
                core_pkg::fn_and:  dec_alu_op = core_pkg::alu_and;
                core_pkg::fn_or:   dec_alu_op = core_pkg::alu_or;
                core_pkg::fn_xor:  dec_alu_op = core_pkg::alu_xor;
                core_pkg::fn_nor:  dec_alu_op = core_pkg::alu_nor;
                core_pkg::fn_slt:  dec_alu_op = core_pkg::alu_slt;
                core_pkg::fn_sltu: dec_alu_op = core_pkg::alu_sltu;
                default:           op_known   = 1'b0;
            endcase
        end else begin
            case (opcode)
                core_pkg::op_addiu: dec_alu_op = core_pkg::alu_add;
                core_pkg::op_slti:  dec_alu_op = core_pkg::alu_slt;
                core_pkg::op_andi:  dec_alu_op = core_pkg::alu_and;
                core_pkg::op_ori:   dec_alu_op = core_pkg::alu_or;
                core_pkg::op_xori:  dec_alu_op = core_pkg::alu_xor;
                core_pkg::op_lui:   dec_alu_op = core_pkg::alu_lui;
                default:            op_known   = 1'b0;
            endcase
        end
    end

    // shifts take sa in place of rs
    assign dec_src_a = is_shift ? {{(`CORE_XLEN-5){1'b0}}, sa} : rs_data;

    always_comb begin
        if (is_special) begin
            dec_src_b = rt_data;
        end else if (opcode == core_pkg::op_addiu || opcode == core_pkg::op_slti) begin
            dec_src_b = {{(`CORE_XLEN-16){imm[15]}}, imm};
        end else begin
            dec_src_b = {{(`CORE_XLEN-16){1'b0}}, imm};
        end
    end

    assign dec_wnum = is_special ? rd_num : rt_num;
    assign dec_wen  = op_known;
    assign dec_pc   = ds_pc;

    // raw interlock, no bypass paths
    assign rs_used = op_known && !is_shift && (opcode != core_pkg::op_lui);
    assign rt_used = op_known && is_special;
    assign rs_hit  = rs_used && (rs_num != '0) &&
                     ((exe_wen && exe_wnum == rs_num) || (res_wen && res_wnum == rs_num));
    assign rt_hit  = rt_used && (rt_num != '0) &&
                     ((exe_wen && exe_wnum == rt_num) || (res_wen && res_wnum == rt_num));
    assign hazard  = ds_valid && (rs_hit || rt_hit);

    assign dec_valid = ds_valid && !hazard;
    assign in_ready  = !ds_valid || (dec_valid && exe_ready);

    // execute only sees bubbles while stalled, so the producer is gone in two cycles
    a_stall_bounded: assert property (
        @(posedge aclk) disable iff (!arst_n)
        hazard && $past(hazard) |=> !hazard
    );

endmodule

// File: design/execute_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module execute_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                dec_valid,
    input  core_pkg::word_t     dec_pc,
    input  core_pkg::alu_op_e   dec_alu_op,
    input  core_pkg::word_t     dec_src_a,
    input  core_pkg::word_t     dec_src_b,
    input  logic                dec_wen,
    input  core_pkg::reg_idx_t  dec_wnum,
    output logic                exe_ready,
    output logic                exe_valid,
    output core_pkg::word_t     exe_pc,
    output core_pkg::word_t     exe_result,
    output logic                exe_wen,
    output core_pkg::reg_idx_t  exe_wnum,
    input  logic                res_ready
);

    logic               es_valid;
    core_pkg::word_t    es_pc;
    core_pkg::alu_op_e  es_alu_op;
    core_pkg::word_t    es_a;
    core_pkg::word_t    es_b;
    logic               es_wen;
    core_pkg::reg_idx_t es_wnum;

    assign exe_ready = !es_valid || res_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            es_valid <= 1'b0;
        end else if (exe_ready) begin
            es_valid <= dec_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (dec_valid && exe_ready) begin
            es_pc     <= dec_pc;
            es_alu_op <= dec_alu_op;
            es_a      <= dec_src_a;
            es_b      <= dec_src_b;
            es_wen    <= dec_wen;
            es_wnum   <= dec_wnum;
        end
    end

    always_comb begin
        case (es_alu_op)
            core_pkg::alu_add:  exe_result = es_a + es_b;
            core_pkg::alu_sub:  exe_result = es_a - es_b;
            core_pkg::alu_and:  exe_result = es_a & es_b;
            core_pkg::alu_or:   exe_result = es_a | es_b;
            core_pkg::alu_xor:  exe_result = es_a ^ es_b;
            core_pkg::alu_nor:  exe_result = ~(es_a | es_b);
            core_pkg::alu_slt:
                exe_result = {{(`CORE_XLEN-1){1'b0}}, $signed(es_a) < $signed(es_b)};
            core_pkg::alu_sltu:
                exe_result = {{(`CORE_XLEN-1){1'b0}}, es_a < es_b};
            // shift amount sits in the low bits of a
            core_pkg::alu_sll:  exe_result = es_b << es_a[4:0];
            core_pkg::alu_srl:  exe_result = es_b >> es_a[4:0];
            core_pkg::alu_sra:
                exe_result = core_pkg::word_t'($signed(es_b) >>> es_a[4:0]);
            core_pkg::alu_lui:
                exe_result = {es_b[15:0], {(`CORE_XLEN-16){1'b0}}};
            default:            exe_result = es_a + es_b;
        endcase
    end

    assign exe_valid = es_valid;
    assign exe_pc    = es_pc;
    assign exe_wen   = es_valid && es_wen;
    assign exe_wnum  = es_wnum;

endmodule

// File: design/result_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module result_stage (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                exe_valid,
    input  core_pkg::word_t     exe_pc,
    input  core_pkg::word_t     exe_result,
    input  logic                exe_wen,
    input  core_pkg::reg_idx_t  exe_wnum,
    output logic                res_ready,
    output logic                res_wen,
    output core_pkg::reg_idx_t  res_wnum,
    output logic                wb_wen,
    output core_pkg::reg_idx_t  wb_wnum,
    output core_pkg::word_t     wb_wdata,
    output logic                trace_valid,
    output core_pkg::word_t     trace_pc,
    output logic                trace_wen,
    output core_pkg::reg_idx_t  trace_wnum,
    output core_pkg::word_t     trace_wdata
);

    logic               rs_valid;
    logic               rs_wen;
    core_pkg::word_t    rs_pc;
    core_pkg::word_t    rs_result;
    core_pkg::reg_idx_t rs_wnum;

    // trace port has no ready, so never stall
    assign res_ready = 1'b1;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rs_valid <= 1'b0;
            rs_wen   <= 1'b0;
        end else if (res_ready) begin
            rs_valid <= exe_valid;
            rs_wen   <= exe_wen && (exe_wnum != `CORE_REG_IDX_W'd0);
        end
    end

    always_ff @(posedge aclk) begin
        if (exe_valid && res_ready) begin
            rs_pc     <= exe_pc;
            rs_result <= exe_result;
            rs_wnum   <= exe_wnum;
        end
    end

    assign res_wen  = rs_valid && rs_wen;
    assign res_wnum = rs_wnum;

    assign wb_wen   = res_wen;
    assign wb_wnum  = rs_wnum;
    assign wb_wdata = rs_result;

    assign trace_valid = rs_valid;
    assign trace_pc    = rs_pc;
    assign trace_wen   = res_wen;
    assign trace_wnum  = rs_wnum;
    assign trace_wdata = rs_result;

    // a retiring write carries a known register and value
    a_trace_write_known: assert property (
        @(posedge aclk) disable iff (!arst_n)
        trace_wen |-> !$isunknown({trace_wnum, trace_wdata})
    );

endmodule

// File: design/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                aclk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  core_pkg::word_t     in_pc,
    input  core_pkg::word_t     in_inst,
    output logic                in_ready,
    output logic                trace_valid,
    output core_pkg::word_t     trace_pc,
    output logic                trace_wen,
    output core_pkg::reg_idx_t  trace_wnum,
    output core_pkg::word_t     trace_wdata
);

    core_pkg::reg_idx_t rs_num;
    core_pkg::reg_idx_t rt_num;
    core_pkg::word_t    rs_data;
    core_pkg::word_t    rt_data;

    logic               dec_valid;
    core_pkg::word_t    dec_pc;
    core_pkg::alu_op_e  dec_alu_op;
    core_pkg::word_t    dec_src_a;
    core_pkg::word_t    dec_src_b;
    logic               dec_wen;
    core_pkg::reg_idx_t dec_wnum;
    logic               exe_ready;

    logic               exe_valid;
    core_pkg::word_t    exe_pc;
    core_pkg::word_t    exe_result;
    logic               exe_wen;
    core_pkg::reg_idx_t exe_wnum;
    logic               res_ready;

    logic               res_wen;
    core_pkg::reg_idx_t res_wnum;
    logic               wb_wen;
    core_pkg::reg_idx_t wb_wnum;
    core_pkg::word_t    wb_wdata;

    reg_file reg_file_i (
        .aclk    (aclk    ),
        .arst_n  (arst_n  ),
        .rs_num  (rs_num  ),
        .rt_num  (rt_num  ),
        .rs_data (rs_data ),
        .rt_data (rt_data ),
        .wen     (wb_wen  ),
        .wnum    (wb_wnum ),
        .wdata   (wb_wdata)
    );

    decode_stage decode_stage_i (
        .aclk       (aclk      ),
        .arst_n     (arst_n    ),
        .in_valid   (in_valid  ),
        .in_pc      (in_pc     ),
        .in_inst    (in_inst   ),
        .in_ready   (in_ready  ),
        .rs_num     (rs_num    ),
        .rt_num     (rt_num    ),
        .rs_data    (rs_data   ),
        .rt_data    (rt_data   ),
        .exe_wen    (exe_wen   ),
        .exe_wnum   (exe_wnum  ),
        .res_wen    (res_wen   ),
        .res_wnum   (res_wnum  ),
        .dec_valid  (dec_valid ),
        .dec_pc     (dec_pc    ),
        .dec_alu_op (dec_alu_op),
        .dec_src_a  (dec_src_a ),
        .dec_src_b  (dec_src_b ),
        .dec_wen    (dec_wen   ),
        .dec_wnum   (dec_wnum  ),
        .exe_ready  (exe_ready )
    );

    execute_stage execute_stage_i (
        .aclk       (aclk      ),
        .arst_n     (arst_n    ),
        .dec_valid  (dec_valid ),
        .dec_pc     (dec_pc    ),
        .dec_alu_op (dec_alu_op),
        .dec_src_a  (dec_src_a ),
        .dec_src_b  (dec_src_b ),
        .dec_wen    (dec_wen   ),
        .dec_wnum   (dec_wnum  ),
        .exe_ready  (exe_ready ),
        .exe_valid  (exe_valid ),
        .exe_pc     (exe_pc    ),
        .exe_result (exe_result),
        .exe_wen    (exe_wen   ),
        .exe_wnum   (exe_wnum  ),
        .res_ready  (res_ready )
    );

    result_stage result_stage_i (
        .aclk        (aclk       ),
        .arst_n      (arst_n     ),
        .exe_valid   (exe_valid  ),
        .exe_pc      (exe_pc     ),
        .exe_result  (exe_result ),
        .exe_wen     (exe_wen    ),
        .exe_wnum    (exe_wnum   ),
        .res_ready   (res_ready  ),
        .res_wen     (res_wen    ),
        .res_wnum    (res_wnum   ),
        .wb_wen      (wb_wen     ),
        .wb_wnum     (wb_wnum    ),
        .wb_wdata    (wb_wdata   ),
        .trace_valid (trace_valid),
        .trace_pc    (trace_pc   ),
        .trace_wen   (trace_wen  ),
        .trace_wnum  (trace_wnum ),
        .trace_wdata (trace_wdata)
    );

endmodule

// File: test/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    localparam int num_cases      = 38;
    localparam int words_per_case = 5;
    localparam int timeout_cycles = 5 * num_cases + 20;

    logic               aclk;
    logic               arst_n;
    logic               in_valid;
    core_pkg::word_t    in_pc;
    core_pkg::word_t    in_inst;
    logic               in_ready;
    logic               trace_valid;
    core_pkg::word_t    trace_pc;
    logic               trace_wen;
    core_pkg::reg_idx_t trace_wnum;
    core_pkg::word_t    trace_wdata;

    logic [31:0]        case_words [0:words_per_case*num_cases-1];
    core_pkg::word_t    case_pc    [0:num_cases-1];
    core_pkg::word_t    case_inst  [0:num_cases-1];
    logic               case_wen   [0:num_cases-1];
    core_pkg::reg_idx_t case_wnum  [0:num_cases-1];
    core_pkg::word_t    case_data  [0:num_cases-1];

    logic [31:0]        rand_state;
    int                 retired     = 0;
    int                 cycle_count = 0;

    core_top core_top_i (
        .aclk        (aclk       ),
        .arst_n      (arst_n     ),
        .in_valid    (in_valid   ),
        .in_pc       (in_pc      ),
        .in_inst     (in_inst    ),
        .in_ready    (in_ready   ),
        .trace_valid (trace_valid),
        .trace_pc    (trace_pc   ),
        .trace_wen   (trace_wen  ),
        .trace_wnum  (trace_wnum ),
        .trace_wdata (trace_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_idx_t got,
                             input core_pkg::reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift_step(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // each line holds pc, inst, wen, wnum and data
    task automatic load_cases();
        $readmemh("test/core_cases.txt", case_words);
        for (int i = 0; i < num_cases; i++) begin
            case_pc[i]   = case_words[words_per_case*i];
            case_inst[i] = case_words[words_per_case*i+1];
            case_wen[i]  = case_words[words_per_case*i+2][0];
            case_wnum[i] = case_words[words_per_case*i+3][4:0];
            case_data[i] = case_words[words_per_case*i+4];
        end
    endtask

    // in_ready only depends on registers, so it is stable at the falling edge
    task automatic offer_case(input int idx);
        logic taken;
        in_valid = 1'b1;
        in_pc    = case_pc[idx];
        in_inst  = case_inst[idx];
        do begin
            taken = in_ready;
            @(negedge aclk);
        end while (!taken);
        in_valid = 1'b0;
    endtask

    // retirement monitor
    always @(negedge aclk) begin
        if (arst_n && trace_valid) begin
            if (retired >= num_cases) begin
                abort_run("an instruction retired after the last case had already retired");
            end else begin
                check_word("trace_pc", trace_pc, case_pc[retired]);
                check_bit("trace_wen", trace_wen, case_wen[retired]);
                if (case_wen[retired]) begin
                    check_reg("trace_wnum", trace_wnum, case_wnum[retired]);
                    check_word("trace_wdata", trace_wdata, case_data[retired]);
                end
                retired = retired + 1;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d instructions retired",
                                cycle_count, retired, num_cases));
        end
    end

    initial begin
        int idle;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        rand_state = 32'd94;
        load_cases();
        repeat (10) @(negedge aclk);
        arst_n = 1'b1;
        @(negedge aclk);
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("trace_valid", trace_valid, 1'b0);
        for (int i = 0; i < num_cases; i++) begin
            rand_state = xorshift_step(rand_state);
            idle = int'(rand_state % 32'd3);
            repeat (idle) @(negedge aclk);
            offer_case(i);
        end
        wait (retired == num_cases);
        // a few more cycles to catch stray retirements
        repeat (4) @(negedge aclk);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: test/core_cases.txt
// columns: pc, instruction word, expected write enable, register, data (hex)
// expected register and data are only compared when the write enable is 1
bfc00000 24010005 1 01 00000005
bfc00004 2402fffd 1 02 fffffffd
bfc00008 00221821 1 03 00000002
bfc0000c 00612023 1 04 fffffffd
bfc00010 3c051234 1 05 12340000
bfc00014 34a55678 1 05 12345678
bfc00018 30a6ff0f 1 06 00005608
bfc0001c 38478001 1 07 ffff7ffc
bfc00020 28480001 1 08 00000001
bfc00024 2829ffff 1 09 00000000
bfc00028 00a25024 1 0a 12345678
bfc0002c 00265825 1 0b 0000560d
bfc00030 00a76026 1 0c edcb2984
bfc00034 00226827 1 0d 00000002
bfc00038 0041702a 1 0e 00000001
bfc0003c 0041782b 1 0f 00000000
bfc00040 00058100 1 10 23456780
bfc00044 00028a02 1 11 00ffffff
bfc00048 00029043 1 12 fffffffe
bfc0004c 00059fc3 1 13 00000000
bfc00050 0004a7c2 1 14 00000001
bfc00054 24200007 0 00 00000000
bfc00058 0001a821 1 15 00000005
bfc0005c 8c220010 0 00 00000000
bfc00060 00220018 0 00 00000000
bfc00064 0040b021 1 16 fffffffd
bfc00068 24170100 1 17 00000100
bfc0006c 02f7c021 1 18 00000200
bfc00070 0317c823 1 19 00000100
bfc00074 2739ffff 1 19 000000ff
bfc00078 0338d02b 1 1a 00000001
bfc0007c 00220021 0 00 00000000
bfc00080 3c1b8000 1 1b 80000000
bfc00084 0360e02a 1 1c 00000001
bfc00088 0360e82b 1 1d 00000000
bfc0008c 001bf023 1 1e 80000000
bfc00090 27dfffff 1 1f 7fffffff
bfc00094 2bff8000 1 1f 00000000

// File: src.f
+incdir+include
design/core_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
test/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module core_tb -o core_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/core_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
